// File: include/stack_core_params.svh
`ifndef STACK_CORE_PARAMS_SVH
`define STACK_CORE_PARAMS_SVH

// Tagged data word, tag over value
`define WORD_WIDTH 19
`define VALUE_WIDTH 16
`define TAG_WIDTH 3

// Instruction word, opcode over signed immediate
`define INSTR_WIDTH 21
`define OPCODE_WIDTH 5

// Data memory size in words
`define DATA_MEM_SIZE 8192

// Stack grows downward from just below the top of data memory
`define STACK_INIT (`DATA_MEM_SIZE - 8)

`endif

// File: hw/stack_core_pkg.sv
`default_nettype none

`include "stack_core_params.svh"

package stack_core_pkg;

	typedef struct packed
	{
		logic [`TAG_WIDTH-1:0] tag;
		logic [`VALUE_WIDTH-1:0] value;
	} tagged_word_t;

	// Frame opcodes stay listed so that they decode as nop
	typedef enum logic [`OPCODE_WIDTH-1:0]
	{
		OP_NOP = 5'd0,
		OP_CALL = 5'd1,
		OP_RETURN = 5'd2,
		OP_POP = 5'd3,
		OP_LOAD = 5'd4,
		OP_STORE = 5'd5,
		OP_ADD = 5'd6,
		OP_SUB = 5'd7,
		OP_REST = 5'd8,
		OP_GTR = 5'd9,
		OP_GTE = 5'd10,
		OP_EQ = 5'd11,
		OP_NEQ = 5'd12,
		OP_DUP = 5'd13,
		OP_GETTAG = 5'd14,
		OP_SETTAG = 5'd15,
		OP_AND = 5'd16,
		OP_OR = 5'd17,
		OP_XOR = 5'd18,
		OP_LSHIFT = 5'd19,
		OP_RSHIFT = 5'd20,
		OP_GETBP = 5'd21,
		OP_RESERVE = 5'd24,
		OP_PUSH = 5'd25,
		OP_GOTO = 5'd26,
		OP_BFALSE = 5'd27,
		OP_GETLOCAL = 5'd29,
		OP_SETLOCAL = 5'd30,
		OP_CLEANUP = 5'd31
	} opcode_t;

	typedef enum logic [2:0]
	{
		ST_FETCH,
		ST_DECODE,
		ST_GOT_NOS,
		ST_GOT_STORE_VALUE,
		ST_GOT_NEW_TAG,
		ST_PUSH_MEM_RESULT,
		ST_BFALSE2
	} seq_state_t;

	typedef enum logic [3:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_GTR,
		ALU_GTE,
		ALU_EQ,
		ALU_NEQ,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_LSHIFT,
		ALU_RSHIFT
	} alu_op_t;

	typedef enum logic {OP0_TOP_OF_STACK, OP0_STACK_POINTER} op0_sel_t;

	typedef enum logic [1:0] {OP1_MEM_READ, OP1_IMMEDIATE, OP1_ONE} op1_sel_t;

	typedef enum logic [2:0]
	{
		TOS_CURRENT,
		TOS_TAG,
		TOS_IMMEDIATE,
		TOS_SETTAG,
		TOS_ALU_RESULT,
		TOS_MEM_RESULT
	} tos_sel_t;

	typedef enum logic [1:0] {SP_CURRENT, SP_DECREMENT, SP_INCREMENT, SP_ALU} sp_sel_t;

	typedef enum logic [1:0] {MA_STACK_POINTER, MA_TOP_OF_STACK, MA_ALU} ma_sel_t;

	typedef enum logic {MW_TOP_OF_STACK, MW_MEM_READ} mw_sel_t;

	typedef enum logic [1:0] {IP_CURRENT, IP_NEXT, IP_BRANCH} ip_sel_t;

endpackage

`default_nettype wire

// File: hw/core_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface core_ctrl_if;
	import stack_core_pkg::*;

	ip_sel_t ip_sel;
	alu_op_t alu_op;
	op0_sel_t op0_sel;
	op1_sel_t op1_sel;
	tos_sel_t tos_sel;
	sp_sel_t sp_sel;
	ma_sel_t ma_sel;
	mw_sel_t mw_sel;
	logic mem_write;

	modport seq(output ip_sel, alu_op, op0_sel, op1_sel, tos_sel, sp_sel, ma_sel, mw_sel,
		mem_write);

	modport fetch(input ip_sel);

	modport datapath(input alu_op, op0_sel, op1_sel, tos_sel, sp_sel);

	// Memory side only needs the address and write controls
	modport mem(input ma_sel, mw_sel, mem_write);

endinterface

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "stack_core_params.svh"

module fetch_unit
(
	input logic clk,
	input logic reset,
	core_ctrl_if.fetch ctrl,
	input logic [`INSTR_WIDTH-1:0] instr_mem_read_value,
	output logic [`VALUE_WIDTH-1:0] instr_mem_address,
	output stack_core_pkg::opcode_t opcode,
	output logic [`WORD_WIDTH-1:0] immediate
);
	import stack_core_pkg::*;

	logic [`VALUE_WIDTH-1:0] instruction_pointer;
	logic [`VALUE_WIDTH-1:0] instruction_pointer_next;

	// Split the fetched word, immediate sign-extended into the tag bits
	assign opcode = opcode_t'(instr_mem_read_value[`INSTR_WIDTH-1:`VALUE_WIDTH]);
	assign immediate = {{`TAG_WIDTH{instr_mem_read_value[`VALUE_WIDTH-1]}},
		instr_mem_read_value[`VALUE_WIDTH-1:0]};

	always_comb
	begin
		case (ctrl.ip_sel)
			IP_NEXT: instruction_pointer_next = instruction_pointer + 16'd1;
			IP_BRANCH: instruction_pointer_next = instruction_pointer + immediate[`VALUE_WIDTH-1:0];
			default: instruction_pointer_next = instruction_pointer;
		endcase
	end

	// Memory sees the next pointer so the word arrives with the register update
	assign instr_mem_address = instruction_pointer_next;

	always_ff @(posedge clk)
	begin
		if (reset)
			instruction_pointer <= '1;
		else
			instruction_pointer <= instruction_pointer_next;
	end

endmodule

`default_nettype wire

// File: hw/sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module sequencer
(
	input logic clk,
	input logic reset,
	input stack_core_pkg::opcode_t opcode,
	input logic tos_zero,
	core_ctrl_if.seq ctrl
);
	import stack_core_pkg::*;

	seq_state_t state;
	seq_state_t state_next;

	function automatic alu_op_t alu_op_for(input opcode_t op);
		case (op)
			OP_ADD: return ALU_ADD;
			OP_GTR: return ALU_GTR;
			OP_GTE: return ALU_GTE;
			OP_EQ: return ALU_EQ;
			OP_NEQ: return ALU_NEQ;
			OP_AND: return ALU_AND;
			OP_OR: return ALU_OR;
			OP_XOR: return ALU_XOR;
			OP_LSHIFT: return ALU_LSHIFT;
			OP_RSHIFT: return ALU_RSHIFT;
			default: return ALU_SUB;
		endcase
	endfunction

	always_comb
	begin
		state_next = state;
		ctrl.ip_sel = IP_CURRENT;
		ctrl.alu_op = alu_op_for(opcode);
		ctrl.op0_sel = OP0_TOP_OF_STACK;
		ctrl.op1_sel = OP1_MEM_READ;
		ctrl.tos_sel = TOS_CURRENT;
		ctrl.sp_sel = SP_CURRENT;
		ctrl.ma_sel = MA_STACK_POINTER;
		ctrl.mw_sel = MW_TOP_OF_STACK;
		ctrl.mem_write = 1'b0;

		// Hold everything still while in reset
		if (!reset)
		begin
			case (state)
				ST_FETCH:
				begin
					ctrl.ip_sel = IP_NEXT;
					state_next = ST_DECODE;
				end

				ST_DECODE:
				begin
					case (opcode)
						OP_POP:
						begin
							ctrl.sp_sel = SP_INCREMENT;
							state_next = ST_PUSH_MEM_RESULT;
						end

						OP_LOAD:
						begin
							ctrl.ma_sel = MA_TOP_OF_STACK;
							state_next = ST_PUSH_MEM_RESULT;
						end

						// Load from TOS + 1
						OP_REST:
						begin
							ctrl.ma_sel = MA_ALU;
							ctrl.op1_sel = OP1_ONE;
							ctrl.alu_op = ALU_ADD;
							state_next = ST_PUSH_MEM_RESULT;
						end

						// Next on stack is read first in all three
						OP_STORE:
							state_next = ST_GOT_STORE_VALUE;
						OP_SETTAG:
							state_next = ST_GOT_NEW_TAG;
						OP_ADD, OP_SUB, OP_GTR, OP_GTE, OP_EQ, OP_NEQ,
						OP_AND, OP_OR, OP_XOR, OP_LSHIFT, OP_RSHIFT:
							state_next = ST_GOT_NOS;

						// Spill TOS to SP - 1, then optionally replace it
						OP_PUSH, OP_DUP:
						begin
							ctrl.sp_sel = SP_DECREMENT;
							ctrl.ma_sel = MA_ALU;
							ctrl.op0_sel = OP0_STACK_POINTER;
							ctrl.op1_sel = OP1_ONE;
							ctrl.alu_op = ALU_SUB;
							ctrl.mem_write = 1'b1;
							if (opcode == OP_PUSH)
								ctrl.tos_sel = TOS_IMMEDIATE;
							ctrl.ip_sel = IP_NEXT;
						end

						OP_GETTAG:
						begin
							ctrl.tos_sel = TOS_TAG;
							ctrl.ip_sel = IP_NEXT;
						end

						OP_GOTO:
							ctrl.ip_sel = IP_BRANCH;

						// Branch now and refill TOS from the stack next cycle
						OP_BFALSE:
						begin
							ctrl.ip_sel = tos_zero ? IP_BRANCH : IP_NEXT;
							ctrl.sp_sel = SP_INCREMENT;
							state_next = ST_BFALSE2;
						end

						// nop and the frame opcodes
						default:
							ctrl.ip_sel = IP_NEXT;
					endcase
				end

				ST_GOT_NOS:
				begin
					ctrl.tos_sel = TOS_ALU_RESULT;
					ctrl.sp_sel = SP_INCREMENT;
					ctrl.ip_sel = IP_NEXT;
					state_next = ST_DECODE;
				end

				// Write NOS to the address in TOS, and keep the stored word on top
				ST_GOT_STORE_VALUE:
				begin
					ctrl.mem_write = 1'b1;
					ctrl.ma_sel = MA_TOP_OF_STACK;
					ctrl.mw_sel = MW_MEM_READ;
					ctrl.tos_sel = TOS_MEM_RESULT;
					ctrl.sp_sel = SP_INCREMENT;
					ctrl.ip_sel = IP_NEXT;
					state_next = ST_DECODE;
				end

				ST_GOT_NEW_TAG:
				begin
					ctrl.tos_sel = TOS_SETTAG;
					ctrl.sp_sel = SP_INCREMENT;
					ctrl.ip_sel = IP_NEXT;
					state_next = ST_DECODE;
				end

				ST_PUSH_MEM_RESULT:
				begin
					ctrl.tos_sel = TOS_MEM_RESULT;
					ctrl.ip_sel = IP_NEXT;
					state_next = ST_DECODE;
				end

				// IP already moved during decode
				ST_BFALSE2:
				begin
					ctrl.tos_sel = TOS_MEM_RESULT;
					state_next = ST_DECODE;
				end

				default:
					state_next = ST_FETCH;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_FETCH;
		else
			state <= state_next;
	end

endmodule

`default_nettype wire

// File: hw/stack_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "stack_core_params.svh"

module stack_alu
(
	input stack_core_pkg::alu_op_t op,
	input logic [`VALUE_WIDTH-1:0] a,
	input logic [`VALUE_WIDTH-1:0] b,
	output logic [`VALUE_WIDTH-1:0] result
);
	import stack_core_pkg::*;

	logic [`VALUE_WIDTH-1:0] diff;
	logic zero;
	logic negative;

	// All compares come from one subtraction
	assign diff = a - b;
	assign zero = (diff == '0);
	assign negative = diff[`VALUE_WIDTH-1];

	always_comb
	begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = diff;
			ALU_GTR: result = {{(`VALUE_WIDTH-1){1'b0}}, !negative && !zero};
			ALU_GTE: result = {{(`VALUE_WIDTH-1){1'b0}}, !negative};
			ALU_EQ: result = {{(`VALUE_WIDTH-1){1'b0}}, zero};
			ALU_NEQ: result = {{(`VALUE_WIDTH-1){1'b0}}, !zero};
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_LSHIFT: result = a << b;
			ALU_RSHIFT: result = a >> b;
			default: result = diff;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/stack_datapath.sv
`timescale 1ns/10ps
`default_nettype none

`include "stack_core_params.svh"

module stack_datapath
(
	input logic clk,
	input logic reset,
	core_ctrl_if.datapath ctrl,
	input logic [`WORD_WIDTH-1:0] immediate,
	input stack_core_pkg::tagged_word_t data_mem_read_value,
	output stack_core_pkg::tagged_word_t top_of_stack,
	output logic [`VALUE_WIDTH-1:0] stack_pointer,
	output logic [`VALUE_WIDTH-1:0] alu_result,
	output logic tos_zero
);
	import stack_core_pkg::*;

	tagged_word_t top_of_stack_next;
	logic [`VALUE_WIDTH-1:0] stack_pointer_next;
	logic [`VALUE_WIDTH-1:0] alu_op0;
	logic [`VALUE_WIDTH-1:0] alu_op1;

	assign alu_op0 = (ctrl.op0_sel == OP0_STACK_POINTER) ? stack_pointer : top_of_stack.value;

	always_comb
	begin
		case (ctrl.op1_sel)
			OP1_IMMEDIATE: alu_op1 = immediate[`VALUE_WIDTH-1:0];
			OP1_ONE: alu_op1 = 16'd1;
			default: alu_op1 = data_mem_read_value.value;
		endcase
	end

	stack_alu i_alu
	(
		.op(ctrl.alu_op),
		.a(alu_op0),
		.b(alu_op1),
		.result(alu_result)
	);

	always_comb
	begin
		top_of_stack_next = top_of_stack;
		case (ctrl.tos_sel)
			TOS_TAG:
			begin
				top_of_stack_next.tag = '0;
				top_of_stack_next.value = {{(`VALUE_WIDTH-`TAG_WIDTH){1'b0}}, top_of_stack.tag};
			end
			TOS_IMMEDIATE: top_of_stack_next = immediate;
			// New tag from NOS, value unchanged
			TOS_SETTAG: top_of_stack_next.tag = data_mem_read_value.value[`TAG_WIDTH-1:0];
			TOS_ALU_RESULT: top_of_stack_next.value = alu_result;
			TOS_MEM_RESULT: top_of_stack_next = data_mem_read_value;
			default: top_of_stack_next = top_of_stack;
		endcase
	end

	always_comb
	begin
		case (ctrl.sp_sel)
			SP_DECREMENT: stack_pointer_next = stack_pointer - 16'd1;
			SP_INCREMENT: stack_pointer_next = stack_pointer + 16'd1;
			SP_ALU: stack_pointer_next = alu_result;
			default: stack_pointer_next = stack_pointer;
		endcase
	end

	assign tos_zero = (top_of_stack.value == '0);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			top_of_stack <= '0;
			stack_pointer <= `VALUE_WIDTH'(`STACK_INIT);
		end
		else
		begin
			top_of_stack <= top_of_stack_next;
			stack_pointer <= stack_pointer_next;
		end
	end

endmodule

`default_nettype wire

// File: hw/data_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "stack_core_params.svh"

module data_mem_port
(
	core_ctrl_if.mem ctrl,
	input stack_core_pkg::tagged_word_t top_of_stack,
	input logic [`VALUE_WIDTH-1:0] stack_pointer,
	input logic [`VALUE_WIDTH-1:0] alu_result,
	input stack_core_pkg::tagged_word_t data_mem_read_value,
	output logic [`VALUE_WIDTH-1:0] data_mem_address,
	output logic [`WORD_WIDTH-1:0] data_mem_write_value,
	output logic data_mem_write_enable
);
	import stack_core_pkg::*;

	always_comb
	begin
		case (ctrl.ma_sel)
			MA_TOP_OF_STACK: data_mem_address = top_of_stack.value;
			// ALU gives SP - 1 for pushes and TOS + 1 for rest
			MA_ALU: data_mem_address = alu_result;
			default: data_mem_address = stack_pointer;
		endcase
	end

	// Store copies NOS straight from the read port
	assign data_mem_write_value = (ctrl.mw_sel == MW_MEM_READ) ? data_mem_read_value
		: top_of_stack;

	assign data_mem_write_enable = ctrl.mem_write;

endmodule

`default_nettype wire

// File: hw/stack_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "stack_core_params.svh"

module stack_core
(
	input logic clk,
	input logic reset,
	output logic [`VALUE_WIDTH-1:0] instr_mem_address,
	input logic [`INSTR_WIDTH-1:0] instr_mem_read_value,
	output logic [`VALUE_WIDTH-1:0] data_mem_address,
	input logic [`WORD_WIDTH-1:0] data_mem_read_value,
	output logic [`WORD_WIDTH-1:0] data_mem_write_value,
	output logic data_mem_write_enable
);
	stack_core_pkg::opcode_t opcode;
	logic [`WORD_WIDTH-1:0] immediate;
	stack_core_pkg::tagged_word_t mem_read_word;
	stack_core_pkg::tagged_word_t top_of_stack;
	logic [`VALUE_WIDTH-1:0] stack_pointer;
	logic [`VALUE_WIDTH-1:0] alu_result;
	logic tos_zero;

	core_ctrl_if ctrl();

	assign mem_read_word = data_mem_read_value;

	fetch_unit i_fetch
	(
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl.fetch),
		.instr_mem_read_value(instr_mem_read_value),
		.instr_mem_address(instr_mem_address),
		.opcode(opcode),
		.immediate(immediate)
	);

	sequencer i_sequencer
	(
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.tos_zero(tos_zero),
		.ctrl(ctrl.seq)
	);

	stack_datapath i_datapath
	(
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl.datapath),
		.immediate(immediate),
		.data_mem_read_value(mem_read_word),
		.top_of_stack(top_of_stack),
		.stack_pointer(stack_pointer),
		.alu_result(alu_result),
		.tos_zero(tos_zero)
	);

	data_mem_port i_mem_port
	(
		.ctrl(ctrl.mem),
		.top_of_stack(top_of_stack),
		.stack_pointer(stack_pointer),
		.alu_result(alu_result),
		.data_mem_read_value(mem_read_word),
		.data_mem_address(data_mem_address),
		.data_mem_write_value(data_mem_write_value),
		.data_mem_write_enable(data_mem_write_enable)
	);

endmodule

`default_nettype wire

// File: testbench/stack_core_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "stack_core_params.svh"

module stack_core_checker
(
	input logic clk,
	input logic reset,
	input logic [`VALUE_WIDTH-1:0] instr_mem_address,
	input logic [`VALUE_WIDTH-1:0] data_mem_address,
	input logic data_mem_write_enable
);
	// Number of assertion failures so far
	int failure_count = 0;

	// Data memory stays untouched while the core is held in reset
	no_write_in_reset: assert property (@(posedge clk) reset |-> !data_mem_write_enable)
	else
	begin
		$error("data memory write enable is high during reset");
		failure_count++;
	end

	write_in_range: assert property (@(posedge clk) disable iff (reset)
		data_mem_write_enable |-> (data_mem_address < `DATA_MEM_SIZE))
	else
	begin
		$error("data memory write to address %0d beyond the memory", data_mem_address);
		failure_count++;
	end

	instr_address_known: assert property (@(posedge clk) !reset |-> !$isunknown(instr_mem_address))
	else
	begin
		$error("instruction memory address is unknown out of reset");
		failure_count++;
	end

endmodule

bind stack_core stack_core_checker i_checker
(
	.clk(clk),
	.reset(reset),
	.instr_mem_address(instr_mem_address),
	.data_mem_address(data_mem_address),
	.data_mem_write_enable(data_mem_write_enable)
);

`default_nettype wire

// File: testbench/tb_stack_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "stack_core_params.svh"

module tb_stack_core;
	import stack_core_pkg::*;

	localparam int ROM_DEPTH = 512;
	localparam int HALT_TIMEOUT = 5000;
	localparam int MODEL_STEP_LIMIT = 5000;

	logic clk;
	logic reset;
	logic [`VALUE_WIDTH-1:0] instr_mem_address;
	logic [`INSTR_WIDTH-1:0] instr_mem_read_value;
	logic [`VALUE_WIDTH-1:0] data_mem_address;
	logic [`WORD_WIDTH-1:0] data_mem_read_value;
	logic [`WORD_WIDTH-1:0] data_mem_write_value;
	logic data_mem_write_enable;

	logic [`INSTR_WIDTH-1:0] rom [0:ROM_DEPTH-1];
	logic [`WORD_WIDTH-1:0] ram [0:`DATA_MEM_SIZE-1];
	logic [`WORD_WIDTH-1:0] model_ram [0:`DATA_MEM_SIZE-1];
	logic [`WORD_WIDTH-1:0] saved_ram [0:`DATA_MEM_SIZE-1];
	int prog_len;
	integer seed;

	// Bus values captured mid-cycle while they are stable
	logic [`VALUE_WIDTH-1:0] instr_address_sampled = '0;
	logic [`VALUE_WIDTH-1:0] data_address_sampled = '0;
	logic [`WORD_WIDTH-1:0] write_value_sampled = '0;
	logic write_enable_sampled = 1'b0;

	stack_core i_dut
	(
		.clk(clk),
		.reset(reset),
		.instr_mem_address(instr_mem_address),
		.instr_mem_read_value(instr_mem_read_value),
		.data_mem_address(data_mem_address),
		.data_mem_read_value(data_mem_read_value),
		.data_mem_write_value(data_mem_write_value),
		.data_mem_write_enable(data_mem_write_enable)
	);

	always #50 clk = ~clk;

	always @(negedge clk)
	begin
		instr_address_sampled = instr_mem_address;
		data_address_sampled = data_mem_address;
		write_value_sampled = data_mem_write_value;
		write_enable_sampled = data_mem_write_enable;
	end

	// Synchronous ROM and read-first RAM
	always @(posedge clk)
	begin
		#1;
		if (instr_address_sampled < ROM_DEPTH)
			instr_mem_read_value = rom[instr_address_sampled];
		else
			instr_mem_read_value = '0;
		data_mem_read_value = ram[data_address_sampled];
		if (write_enable_sampled === 1'b1)
			ram[data_address_sampled] = write_value_sampled;
	end

	// Stop at the first bus assertion failure
	always @(posedge clk)
	begin
		if (i_dut.i_checker.failure_count != 0)
		begin
			$display("Test failed");
			$fatal(1, "Bus assertion failed");
		end
	end

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("Test failed");
			$fatal(1, "Value mismatch");
		end
	endtask

	function automatic logic [`WORD_WIDTH-1:0] fill_word(input int unsigned address);
		logic [15:0] a;
		a = address[15:0];
		return {a[2:0] ^ a[12:10], (a * 16'h02f1) ^ 16'ha5c3};
	endfunction

	// Reference ALU with operand a as the top of stack
	function automatic logic [15:0] expected_alu_result(input opcode_t op, input logic [15:0] a,
		input logic [15:0] b);
		logic [15:0] diff;
		diff = a - b;
		case (op)
			OP_ADD: return a + b;
			OP_GTR: return {15'd0, !diff[15] && (diff != 16'd0)};
			OP_GTE: return {15'd0, !diff[15]};
			OP_EQ: return {15'd0, diff == 16'd0};
			OP_NEQ: return {15'd0, diff != 16'd0};
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			OP_LSHIFT: return a << b;
			OP_RSHIFT: return a >> b;
			default: return diff;
		endcase
	endfunction

	task automatic add_instr(input opcode_t op, input logic [15:0] imm);
		rom[prog_len] = {op, imm};
		prog_len++;
	endtask

	// Store TOS at a fixed address and restore the stack depth
	task automatic store_result(input logic [15:0] address);
		add_instr(OP_PUSH, address);
		add_instr(OP_STORE, 16'd0);
		add_instr(OP_POP, 16'd0);
	endtask

	task automatic begin_program();
		int address;
		@(posedge clk);
		#1;
		reset = 1'b1;
		@(negedge clk);
		for (address = 0; address < ROM_DEPTH; address++)
			rom[address] = '0;
		for (address = 0; address < `DATA_MEM_SIZE; address++)
		begin
			ram[address] = fill_word(address);
			model_ram[address] = fill_word(address);
		end
		prog_len = 0;
	endtask

	task automatic wait_for_halt(input logic [15:0] halt_address);
		int stable_cycles;
		int waited;
		stable_cycles = 0;
		waited = 0;
		while (stable_cycles < 3)
		begin
			@(negedge clk);
			waited++;
			if (instr_mem_address === halt_address)
				stable_cycles++;
			else
				stable_cycles = 0;
			if (waited > HALT_TIMEOUT)
			begin
				$display("Timeout: the program never settled on its final goto at %0d",
					halt_address);
				$display("Test failed");
				$fatal(1, "Timeout waiting for the program to finish");
			end
		end
	endtask

	// Instruction-level model of the core on model_ram
	task automatic run_model();
		tagged_word_t tos;
		tagged_word_t nos;
		logic [15:0] sp;
		logic [15:0] ip;
		logic [15:0] ip_next;
		logic [15:0] imm;
		opcode_t op;
		int steps;
		tos = '0;
		sp = 16'(`STACK_INIT);
		ip = 16'd0;
		steps = 0;
		while (rom[ip] !== {OP_GOTO, 16'd0})
		begin
			if (steps > MODEL_STEP_LIMIT)
			begin
				$display("Reference model ran too long without reaching the final goto");
				$display("Test failed");
				$fatal(1, "Reference model did not finish");
			end
			op = opcode_t'(rom[ip][`INSTR_WIDTH-1:`VALUE_WIDTH]);
			imm = rom[ip][`VALUE_WIDTH-1:0];
			nos = model_ram[sp];
			ip_next = ip + 16'd1;
			case (op)
				OP_PUSH:
				begin
					model_ram[sp - 16'd1] = tos;
					sp = sp - 16'd1;
					tos = {{`TAG_WIDTH{imm[15]}}, imm};
				end
				OP_DUP:
				begin
					model_ram[sp - 16'd1] = tos;
					sp = sp - 16'd1;
				end
				OP_POP:
				begin
					tos = nos;
					sp = sp + 16'd1;
				end
				OP_LOAD:
					tos = model_ram[tos.value];
				OP_REST:
					tos = model_ram[tos.value + 16'd1];
				OP_STORE:
				begin
					model_ram[tos.value] = nos;
					tos = nos;
					sp = sp + 16'd1;
				end
				OP_GETTAG:
				begin
					tos.value = 16'(tos.tag);
					tos.tag = '0;
				end
				OP_SETTAG:
				begin
					tos.tag = nos.value[`TAG_WIDTH-1:0];
					sp = sp + 16'd1;
				end
				OP_ADD, OP_SUB, OP_GTR, OP_GTE, OP_EQ, OP_NEQ,
				OP_AND, OP_OR, OP_XOR, OP_LSHIFT, OP_RSHIFT:
				begin
					tos.value = expected_alu_result(op, tos.value, nos.value);
					sp = sp + 16'd1;
				end
				OP_GOTO:
					ip_next = ip + imm;
				OP_BFALSE:
				begin
					if (tos.value == 16'd0)
						ip_next = ip + imm;
					tos = nos;
					sp = sp + 16'd1;
				end
				default:
					ip_next = ip + 16'd1;
			endcase
			ip = ip_next;
			steps++;
		end
	endtask

	task automatic compare_ram();
		int address;
		for (address = 0; address < `DATA_MEM_SIZE; address++)
			check_value($sformatf("RAM word %0d", address), ram[address], model_ram[address]);
	endtask

	task automatic run_program();
		logic [15:0] halt_address;
		halt_address = 16'(prog_len);
		add_instr(OP_GOTO, 16'd0);
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		wait_for_halt(halt_address);
		run_model();
		compare_ram();
	endtask

	task automatic push_and_store();
		begin_program();
		add_instr(OP_PUSH, 16'h1234);
		store_result(16'd200);
		add_instr(OP_PUSH, 16'hff80);
		store_result(16'd201);
		run_program();
		check_value("stored positive word", ram[200], {3'b000, 16'h1234});
	endtask

	task automatic alu_operations();
		opcode_t ops [0:10];
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] address;
		int p;
		int k;
		ops = '{OP_ADD, OP_SUB, OP_GTR, OP_GTE, OP_EQ, OP_NEQ,
			OP_AND, OP_OR, OP_XOR, OP_LSHIFT, OP_RSHIFT};
		begin_program();
		address = 16'd1000;
		for (p = 0; p < 3; p++)
		begin
			a = $random(seed);
			b = $random(seed);
			// Small shift amount in the first pair and equal operands in the second
			if (p == 0)
				b = b & 16'h000f;
			if (p == 1)
				b = a;
			for (k = 0; k < 11; k++)
			begin
				add_instr(OP_PUSH, b);
				add_instr(OP_PUSH, a);
				add_instr(ops[k], 16'd0);
				store_result(address);
				address++;
			end
		end
		run_program();
		check_value("eq of equal operands", ram[1015][15:0], 16'd1);
	endtask

	task automatic memory_reads();
		begin_program();
		add_instr(OP_PUSH, 16'd300);
		add_instr(OP_LOAD, 16'd0);
		store_result(16'd400);
		add_instr(OP_PUSH, 16'd310);
		add_instr(OP_REST, 16'd0);
		store_result(16'd401);
		add_instr(OP_PUSH, 16'd7);
		add_instr(OP_PUSH, 16'd8);
		add_instr(OP_POP, 16'd0);
		store_result(16'd402);
		add_instr(OP_PUSH, 16'd9);
		add_instr(OP_DUP, 16'd0);
		add_instr(OP_ADD, 16'd0);
		store_result(16'd403);
		run_program();
		check_value("loaded word", ram[400], fill_word(300));
		check_value("rest word", ram[401], fill_word(311));
		check_value("popped word", ram[402], 32'd7);
		check_value("dup sum", ram[403], 32'd18);
	endtask

	task automatic tag_handling();
		begin_program();
		add_instr(OP_PUSH, 16'd6);
		add_instr(OP_PUSH, 16'h0abc);
		add_instr(OP_SETTAG, 16'd0);
		add_instr(OP_DUP, 16'd0);
		store_result(16'd500);
		add_instr(OP_GETTAG, 16'd0);
		store_result(16'd501);
		add_instr(OP_PUSH, 16'hfff5);
		add_instr(OP_PUSH, 16'h0123);
		add_instr(OP_SETTAG, 16'd0);
		store_result(16'd502);
		add_instr(OP_PUSH, 16'd333);
		add_instr(OP_LOAD, 16'd0);
		add_instr(OP_GETTAG, 16'd0);
		store_result(16'd503);
		run_program();
		check_value("settag word", ram[500], {3'd6, 16'h0abc});
		check_value("gettag word", ram[501], 32'd6);
		check_value("settag from low bits", ram[502], {3'd5, 16'h0123});
	endtask

	task automatic control_flow();
		begin_program();
		add_instr(OP_PUSH, 16'h00aa);
		store_result(16'd600);
		// Jump over one marker block
		add_instr(OP_GOTO, 16'd5);
		add_instr(OP_PUSH, 16'h00bb);
		store_result(16'd601);
		add_instr(OP_PUSH, 16'd0);
		add_instr(OP_BFALSE, 16'd5);
		add_instr(OP_PUSH, 16'h00cc);
		store_result(16'd602);
		add_instr(OP_PUSH, 16'd1);
		add_instr(OP_BFALSE, 16'd5);
		add_instr(OP_PUSH, 16'h00dd);
		store_result(16'd603);
		run_program();
		check_value("marker before goto", ram[600], 32'h00aa);
		check_value("marker skipped by goto", ram[601], fill_word(601));
		check_value("marker skipped by bfalse", ram[602], fill_word(602));
		check_value("marker after bfalse fall-through", ram[603], 32'h00dd);
	endtask

	task automatic build_mixed_program(input logic with_dropped);
		add_instr(OP_PUSH, 16'd3);
		if (with_dropped)
			add_instr(OP_CALL, 16'd7);
		add_instr(OP_PUSH, 16'd4);
		if (with_dropped)
			add_instr(OP_RESERVE, 16'd2);
		add_instr(OP_ADD, 16'd0);
		if (with_dropped)
			add_instr(OP_CALL, 16'hfff0);
		store_result(16'd700);
		add_instr(OP_PUSH, 16'h0055);
		add_instr(OP_DUP, 16'd0);
		if (with_dropped)
			add_instr(OP_RESERVE, 16'd9);
		add_instr(OP_XOR, 16'd0);
		store_result(16'd701);
	endtask

	task automatic dropped_opcodes_as_nop();
		int address;
		begin_program();
		build_mixed_program(1'b1);
		run_program();
		saved_ram = ram;
		begin_program();
		build_mixed_program(1'b0);
		run_program();
		for (address = 0; address < `DATA_MEM_SIZE; address++)
			check_value($sformatf("RAM word %0d without dropped opcodes", address),
				ram[address], saved_ram[address]);
		check_value("sum next to dropped opcodes", ram[700], 32'd7);
		check_value("xor of duplicates", ram[701], 32'd0);
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		instr_mem_read_value = '0;
		data_mem_read_value = '0;
		seed = 32'h6d69;
		prog_len = 0;

		push_and_store();
		alu_operations();
		memory_reads();
		tag_handling();
		control_flow();
		dropped_opcodes_as_nop();

		if (i_dut.i_checker.failure_count == 0)
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
		begin
			$display("Bus assertions failed %0d times", i_dut.i_checker.failure_count);
			$display("Test failed");
			$fatal(1, "Bus assertion failed");
		end
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
hw/stack_core_pkg.sv
hw/core_ctrl_if.sv
hw/fetch_unit.sv
hw/sequencer.sv
hw/stack_alu.sv
hw/stack_datapath.sv
hw/data_mem_port.sv
hw/stack_core.sv
testbench/stack_core_checker.sv
testbench/tb_stack_core.sv

// File: Bender.yml
package:
  name: stack_core

export_include_dirs:
  - include

sources:
  - files:
      - hw/stack_core_pkg.sv
      - hw/core_ctrl_if.sv
      - hw/fetch_unit.sv
      - hw/sequencer.sv
      - hw/stack_alu.sv
      - hw/stack_datapath.sv
      - hw/data_mem_port.sv
      - hw/stack_core.sv
  - target: test
    files:
      - testbench/stack_core_checker.sv
      - testbench/tb_stack_core.sv
